// File: hw/branchIsaPkg.sv
`default_nettype none

package branchIsaPkg;

    // Data path and fetch address width
    localparam int dataWidth = 16;

    // Width of the immediate branch offset field
    localparam int immFieldWidth = 10;

    typedef logic [15:0] instrT;
    typedef logic [dataWidth-1:0] addrT;

    // One fetched instruction with the address it came from
    typedef struct packed {
        addrT address;
        instrT instruction;
    } fetchT;

    // Resolution from the stage that executes the branch
    typedef struct packed {
        logic endPulse;
        logic mispredicted;
        addrT actualDestination;
    } resolveT;

    // Decoder results for the fetched word
    typedef struct packed {
        logic isBranch;
        logic immediateForm;
        logic regAZero;
        logic needsSpeculation;
        addrT immTarget;
    } decodedT;

    // Prediction as seen by the fetch stage
    typedef struct packed {
        logic speculating;
        logic beginPulse;
        logic relative;
        logic predictTaken;
        logic stall;
        addrT destination;
    } predictionT;

endpackage

`default_nettype wire

// File: hw/branchPredPkg.sv
`default_nettype none

package branchPredPkg;

    // Table geometry
    localparam int indexWidth = 6;
    localparam int tableDepth = 64;

    // Low address bits copied straight into the index
    localparam int preservedBits = 3;

    typedef logic [indexWidth-1:0] indexT;

    // Two-bit saturating counter, upper bit is the prediction
    typedef logic [1:0] counterT;

    localparam counterT ctrStrongNotTaken = 2'd0;
    localparam counterT ctrStrongTaken = 2'd3;

    // Starting points for entries that were never trained
    localparam counterT immInitCounter = 2'd2;
    localparam counterT btbInitCounter = 2'd1;

    typedef struct packed {
        counterT counter;
    } immEntryT;

    typedef struct packed {
        counterT counter;
        branchIsaPkg::addrT destination;
    } btbEntryT;

    // One step toward the outcome, saturating at both ends
    function automatic counterT nextCounter(counterT current, logic taken);
        counterT result;
        result = current;
        if (taken) begin
            if (current != ctrStrongTaken) begin
                result = current + 2'd1;
            end
        end else begin
            if (current != ctrStrongNotTaken) begin
                result = current - 2'd1;
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: hw/addressHasher.sv
`default_nettype none

module addressHasher (
    input  branchIsaPkg::addrT   address,
    output branchPredPkg::indexT index
);

    localparam int hashBits = branchPredPkg::indexWidth - branchPredPkg::preservedBits;

    logic [hashBits-1:0] folded;

    // XOR the upper address bits down in groups of hashBits
    always_comb begin
        folded = '0;
        for (int i = branchPredPkg::preservedBits; i < branchIsaPkg::dataWidth; i++) begin
            folded[(i - branchPredPkg::preservedBits) % hashBits] ^= address[i];
        end
    end

    // Neighbouring instructions keep distinct low index bits
    assign index = {folded, address[branchPredPkg::preservedBits-1:0]};

endmodule

`default_nettype wire

// File: hw/branchDecoder.sv
`default_nettype none

module branchDecoder (
    input  branchIsaPkg::instrT   instruction,
    output branchIsaPkg::decodedT decoded
);

    localparam int signWidth = branchIsaPkg::dataWidth - branchIsaPkg::immFieldWidth;

    logic immForm;
    logic immRegAZero;
    logic regRegAZero;

    assign immForm = instruction[12];

    // Register A field is narrower in the immediate form
    assign immRegAZero = (instruction[11:10] == 2'b00);
    assign regRegAZero = (instruction[11:8] == 4'b0000);

    always_comb begin
        decoded.isBranch = instruction[15] & ~instruction[14];
        decoded.immediateForm = immForm;
        decoded.regAZero = immForm ? immRegAZero : regRegAZero;
        // Immediate jump against zero is unconditional and known at fetch
        decoded.needsSpeculation = decoded.isBranch & ~(immForm & immRegAZero);
        decoded.immTarget = {
            {signWidth{instruction[branchIsaPkg::immFieldWidth-1]}},
            instruction[branchIsaPkg::immFieldWidth-1:0]
        };
    end

endmodule

`default_nettype wire

// File: hw/predictionTable.sv
`default_nettype none

module predictionTable #(
    parameter type entryT = logic
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 clkEn,

    input  branchPredPkg::indexT readIndex,
    output logic                 readValid,
    output entryT                readEntry,

    input  logic                 writeEnable,
    input  branchPredPkg::indexT writeIndex,
    input  entryT                writeEntry
);

    entryT entries [branchPredPkg::tableDepth];
    logic [branchPredPkg::tableDepth-1:0] valid;

    // Entry marked valid on its first write
    always_ff @(posedge clk) begin
        if (!rstN) begin
            valid <= '0;
        end else if (clkEn && writeEnable) begin
            valid[writeIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && writeEnable) begin
            entries[writeIndex] <= writeEntry;
        end
    end

    // Asynchronous read, same cycle as the fetch
    assign readValid = valid[readIndex];
    assign readEntry = entries[readIndex];

endmodule

`default_nettype wire

// File: hw/speculationControl.sv
`default_nettype none

module speculationControl (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   clkEn,

    input  branchIsaPkg::decodedT  decoded,
    input  branchPredPkg::indexT   freshIndex,
    input  logic                   endPulse,
    input  logic                   taken,

    output logic                   speculating,
    output logic                   beginPulse,
    output logic                   stall,
    output logic                   storedImmediate,
    output branchPredPkg::indexT   activeIndex,
    output branchPredPkg::counterT globalCounter
);

    branchPredPkg::indexT storedIndex;

    // Only one branch in flight, a second one waits
    assign beginPulse = decoded.needsSpeculation & ~speculating;
    assign stall = decoded.needsSpeculation & speculating;

    // Status and the form of the branch being speculated
    always_ff @(posedge clk) begin
        if (!rstN) begin
            speculating <= 1'b0;
            storedImmediate <= 1'b0;
        end else if (clkEn) begin
            if (endPulse) begin
                speculating <= 1'b0;
            end else if (beginPulse) begin
                speculating <= 1'b1;
                storedImmediate <= decoded.immediateForm;
            end
        end
    end

    // Index kept for the update at resolution
    always_ff @(posedge clk) begin
        if (clkEn && beginPulse && !endPulse) begin
            storedIndex <= freshIndex;
        end
    end

    assign activeIndex = speculating ? storedIndex : freshIndex;

    // Global counter trains on every resolved branch
    always_ff @(posedge clk) begin
        if (!rstN) begin
            globalCounter <= branchPredPkg::ctrStrongNotTaken;
        end else if (clkEn && endPulse) begin
            globalCounter <= branchPredPkg::nextCounter(globalCounter, taken);
        end
    end

endmodule

`default_nettype wire

// File: hw/branchExaminer.sv
`default_nettype none

module branchExaminer (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     clkEn,

    input  branchIsaPkg::fetchT      fetch,
    input  branchIsaPkg::resolveT    resolve,
    output branchIsaPkg::predictionT prediction
);

    branchIsaPkg::decodedT  decoded;
    branchPredPkg::indexT   freshIndex;
    branchPredPkg::indexT   activeIndex;
    branchPredPkg::counterT globalCounter;

    logic speculating;
    logic beginPulse;
    logic stall;
    logic storedImmediate;
    logic taken;

    logic                   immValid;
    branchPredPkg::immEntryT immEntry;
    branchPredPkg::immEntryT immWrite;
    logic                   btbValid;
    branchPredPkg::btbEntryT btbEntry;
    branchPredPkg::btbEntryT btbWrite;

    // No mispredict means the predicted path was taken
    assign taken = ~resolve.mispredicted;

    branchDecoder decoder (
        .instruction(fetch.instruction),
        .decoded    (decoded)
    );

    addressHasher hasher (
        .address(fetch.address),
        .index  (freshIndex)
    );

    speculationControl specControl (
        .clk            (clk),
        .rstN           (rstN),
        .clkEn          (clkEn),
        .decoded        (decoded),
        .freshIndex     (freshIndex),
        .endPulse       (resolve.endPulse),
        .taken          (taken),
        .speculating    (speculating),
        .beginPulse     (beginPulse),
        .stall          (stall),
        .storedImmediate(storedImmediate),
        .activeIndex    (activeIndex),
        .globalCounter  (globalCounter)
    );

    // Untrained entries count from their init value
    always_comb begin
        immWrite.counter = branchPredPkg::nextCounter(
            immValid ? immEntry.counter : branchPredPkg::immInitCounter, taken);
        btbWrite.counter = branchPredPkg::nextCounter(
            btbValid ? btbEntry.counter : branchPredPkg::btbInitCounter, taken);
        btbWrite.destination = resolve.actualDestination;
    end

    predictionTable #(
        .entryT(branchPredPkg::immEntryT)
    ) immTable (
        .clk        (clk),
        .rstN       (rstN),
        .clkEn      (clkEn),
        .readIndex  (activeIndex),
        .readValid  (immValid),
        .readEntry  (immEntry),
        .writeEnable(resolve.endPulse & storedImmediate),
        .writeIndex (activeIndex),
        .writeEntry (immWrite)
    );

    predictionTable #(
        .entryT(branchPredPkg::btbEntryT)
    ) btbTable (
        .clk        (clk),
        .rstN       (rstN),
        .clkEn      (clkEn),
        .readIndex  (activeIndex),
        .readValid  (btbValid),
        .readEntry  (btbEntry),
        .writeEnable(resolve.endPulse & ~storedImmediate),
        .writeIndex (activeIndex),
        .writeEntry (btbWrite)
    );

    always_comb begin
        prediction.speculating = speculating;
        prediction.beginPulse = beginPulse;
        prediction.stall = stall;
        prediction.relative = decoded.immediateForm;

        // Compare against zero always branches
        if (decoded.regAZero) begin
            prediction.predictTaken = 1'b1;
        end else if (decoded.immediateForm) begin
            prediction.predictTaken = immValid ? immEntry.counter[1] : globalCounter[1];
        end else begin
            prediction.predictTaken = btbValid ? btbEntry.counter[1] : 1'b1;
        end

        if (decoded.immediateForm) begin
            prediction.destination = decoded.immTarget;
        end else if (btbValid) begin
            prediction.destination = btbEntry.destination;
        end else begin
            prediction.destination = '0;
        end
    end

endmodule

`default_nettype wire

// File: dv/branchExaminerTb.sv
`default_nettype none

module branchExaminerTb;

    localparam int plannedBranches = 43;
    // Each branch takes three cycles and the margin covers reset and idle cycles
    localparam int timeoutCycles = plannedBranches * 4 + 60;
    localparam branchIsaPkg::instrT nopInstr = 16'h0000;

    logic clk;
    logic rstN;
    logic clkEn;
    branchIsaPkg::fetchT      fetch;
    branchIsaPkg::resolveT    resolve;
    branchIsaPkg::predictionT prediction;

    // Reference model state
    branchPredPkg::counterT modelImmCounter [branchPredPkg::tableDepth];
    logic                   modelImmValid [branchPredPkg::tableDepth];
    branchPredPkg::counterT modelBtbCounter [branchPredPkg::tableDepth];
    branchIsaPkg::addrT     modelBtbDest [branchPredPkg::tableDepth];
    logic                   modelBtbValid [branchPredPkg::tableDepth];
    branchPredPkg::counterT modelGlobal;
    logic                   modelSpeculating;
    logic                   modelStoredImm;
    branchPredPkg::indexT   modelStoredIndex;

    int errors;
    int cycles;
    int seed = 8679;
    logic [31:0] rnd;

    branchExaminer branchExaminer_i (
        .clk       (clk),
        .rstN      (rstN),
        .clkEn     (clkEn),
        .fetch     (fetch),
        .resolve   (resolve),
        .prediction(prediction)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic branchPredPkg::indexT hashIndex(input branchIsaPkg::addrT addr);
        logic [2:0] folded;
        // Bit 15 lands on folded bit 0
        folded = addr[5:3] ^ addr[8:6] ^ addr[11:9] ^ addr[14:12] ^ {2'b00, addr[15]};
        return {folded, addr[2:0]};
    endfunction

    function automatic branchPredPkg::counterT stepCounter(input branchPredPkg::counterT c,
                                                           input logic taken);
        if (taken) begin
            return (c == 2'd3) ? 2'd3 : c + 2'd1;
        end
        return (c == 2'd0) ? 2'd0 : c - 2'd1;
    endfunction

    function automatic branchPredPkg::indexT activeModelIndex(input branchIsaPkg::addrT addr);
        return modelSpeculating ? modelStoredIndex : hashIndex(addr);
    endfunction

    // Expected outputs for the fetch word against the current model state
    function automatic branchIsaPkg::predictionT expectedPrediction(input branchIsaPkg::fetchT f);
        branchIsaPkg::predictionT exp;
        branchPredPkg::indexT idx;
        logic isBranch;
        logic immForm;
        logic regAZero;
        logic needsSpec;
        isBranch = (f.instruction[15:14] == 2'b10);
        immForm = f.instruction[12];
        regAZero = immForm ? (f.instruction[11:10] == 2'b00) : (f.instruction[11:8] == 4'h0);
        needsSpec = isBranch && !(immForm && regAZero);
        idx = activeModelIndex(f.address);
        exp.speculating = modelSpeculating;
        exp.beginPulse = needsSpec && !modelSpeculating;
        exp.stall = needsSpec && modelSpeculating;
        exp.relative = immForm;
        if (regAZero) begin
            exp.predictTaken = 1'b1;
        end else if (immForm) begin
            exp.predictTaken = modelImmValid[idx] ? modelImmCounter[idx][1] : modelGlobal[1];
        end else begin
            exp.predictTaken = modelBtbValid[idx] ? modelBtbCounter[idx][1] : 1'b1;
        end
        if (immForm) begin
            exp.destination = {{6{f.instruction[9]}}, f.instruction[9:0]};
        end else begin
            exp.destination = modelBtbValid[idx] ? modelBtbDest[idx] : 16'h0000;
        end
        return exp;
    endfunction

    function automatic branchIsaPkg::instrT immInstr(input logic [1:0] regA,
                                                     input logic [9:0] offset);
        return {4'b1001, regA, offset};
    endfunction

    function automatic branchIsaPkg::instrT regInstr(input logic [3:0] regA);
        return {4'b1000, regA, 8'h5a};
    endfunction

    task automatic checkPrediction(input string name, input branchIsaPkg::predictionT got,
                                   input branchIsaPkg::predictionT exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h at cycle %0d", name, got, exp, cycles);
        end
    endtask

    task automatic checkCounter(input string name, input branchPredPkg::counterT got,
                                input branchPredPkg::counterT exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h at cycle %0d", name, got, exp, cycles);
        end
    endtask

    task automatic present(input branchIsaPkg::addrT addr, input branchIsaPkg::instrT instr);
        @(posedge clk);
        fetch.address <= addr;
        fetch.instruction <= instr;
        resolve.endPulse <= 1'b0;
    endtask

    task automatic resolveBranch(input logic mispred, input branchIsaPkg::addrT dest);
        @(posedge clk);
        fetch.instruction <= nopInstr;
        resolve.endPulse <= 1'b1;
        resolve.mispredicted <= mispred;
        resolve.actualDestination <= dest;
        @(posedge clk);
        resolve.endPulse <= 1'b0;
    endtask

    // Present a branch, wait for it to be accepted, then resolve it
    task automatic runBranch(input branchIsaPkg::addrT addr, input branchIsaPkg::instrT instr,
                             input logic mispred, input branchIsaPkg::addrT dest);
        present(addr, instr);
        @(negedge clk);
        while (!prediction.beginPulse) begin
            @(negedge clk);
        end
        resolveBranch(mispred, dest);
    endtask

    // Model follows the same edge as the DUT state
    always @(posedge clk) begin
        branchIsaPkg::predictionT exp;
        branchPredPkg::indexT idx;
        logic taken;
        if (!rstN) begin
            for (int i = 0; i < branchPredPkg::tableDepth; i++) begin
                modelImmValid[i] = 1'b0;
                modelBtbValid[i] = 1'b0;
            end
            modelGlobal = 2'd0;
            modelSpeculating = 1'b0;
            modelStoredImm = 1'b0;
        end else if (clkEn) begin
            exp = expectedPrediction(fetch);
            idx = activeModelIndex(fetch.address);
            taken = ~resolve.mispredicted;
            if (resolve.endPulse) begin
                modelGlobal = stepCounter(modelGlobal, taken);
                if (modelStoredImm) begin
                    modelImmCounter[idx] = stepCounter(modelImmValid[idx] ? modelImmCounter[idx]
                        : branchPredPkg::immInitCounter, taken);
                    modelImmValid[idx] = 1'b1;
                end else begin
                    modelBtbCounter[idx] = stepCounter(modelBtbValid[idx] ? modelBtbCounter[idx]
                        : branchPredPkg::btbInitCounter, taken);
                    modelBtbDest[idx] = resolve.actualDestination;
                    modelBtbValid[idx] = 1'b1;
                end
                modelSpeculating = 1'b0;
            end else if (exp.beginPulse) begin
                modelSpeculating = 1'b1;
                modelStoredImm = fetch.instruction[12];
                modelStoredIndex = hashIndex(fetch.address);
            end
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        branchPredPkg::indexT idx;
        if (rstN) begin
            idx = activeModelIndex(fetch.address);
            checkPrediction("prediction", prediction, expectedPrediction(fetch));
            checkCounter("globalCounter", branchExaminer_i.specControl.globalCounter,
                         modelGlobal);
            if (modelImmValid[idx]) begin
                checkCounter("immEntry.counter", branchExaminer_i.immEntry.counter,
                             modelImmCounter[idx]);
            end
            if (modelBtbValid[idx]) begin
                checkCounter("btbEntry.counter", branchExaminer_i.btbEntry.counter,
                             modelBtbCounter[idx]);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
    end

    initial begin
        while (cycles < timeoutCycles) begin
            @(negedge clk);
        end
        $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [1:0] regA;
        rstN = 1'b0;
        clkEn = 1'b1;
        fetch = '0;
        resolve = '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        // Idle after reset
        @(negedge clk);
        if (prediction.speculating || prediction.beginPulse || prediction.stall) begin
            errors++;
            $display("Speculation outputs were not low after reset");
        end

        // Register form with a cold entry first and trained destinations after
        runBranch(16'h0a48, regInstr(4'h5), 1'b0, 16'h1234);
        runBranch(16'h0a48, regInstr(4'h5), 1'b1, 16'h2f00);
        runBranch(16'h0a48, regInstr(4'h5), 1'b0, 16'h2f00);

        // Immediate form at random addresses
        for (int k = 0; k < 20; k++) begin
            rnd = $random(seed);
            regA = (rnd[17:16] == 2'd0) ? 2'd1 : rnd[17:16];
            runBranch(rnd[15:0], immInstr(regA, rnd[27:18]), rnd[31], rnd[15:0] ^ 16'h00f0);
        end

        // Saturate up and down on one address of each form
        for (int k = 0; k < 4; k++) begin
            runBranch(16'h0120, immInstr(2'd2, 10'h3f0), 1'b0, 16'h0000);
        end
        for (int k = 0; k < 5; k++) begin
            runBranch(16'h0120, immInstr(2'd2, 10'h3f0), 1'b1, 16'h0000);
        end
        for (int k = 0; k < 3; k++) begin
            runBranch(16'h0a48, regInstr(4'h5), 1'b0, 16'h3c00);
        end
        for (int k = 0; k < 4; k++) begin
            runBranch(16'h0a48, regInstr(4'h5), 1'b1, 16'h3c40);
        end

        // Second branch while the first is in flight
        present(16'h0200, immInstr(2'd1, 10'h040));
        @(posedge clk);
        fetch.address <= 16'h0a48;
        fetch.instruction <= regInstr(4'h3);
        @(negedge clk);
        if (!prediction.stall) begin
            errors++;
            $display("Second branch was not stalled while speculating");
        end
        @(posedge clk);
        resolve.endPulse <= 1'b1;
        resolve.mispredicted <= 1'b0;
        resolve.actualDestination <= 16'h0000;
        @(negedge clk);
        if (!prediction.stall) begin
            errors++;
            $display("Second branch was not stalled in the resolution cycle");
        end
        @(posedge clk);
        resolve.endPulse <= 1'b0;
        @(negedge clk);
        if (prediction.stall || !prediction.beginPulse) begin
            errors++;
            $display("Stalled branch did not begin right after the resolution");
        end
        resolveBranch(1'b0, 16'h0a80);

        // Immediate form against regA zero needs no speculation
        present(16'h0300, immInstr(2'd0, 10'h155));
        @(negedge clk);
        if (prediction.beginPulse || !prediction.predictTaken) begin
            errors++;
            $display("Immediate branch against zero speculated or was not predicted taken");
        end
        runBranch(16'h0308, regInstr(4'h0), 1'b1, 16'h0444);

        // Nothing may change while clkEn is low
        @(posedge clk);
        clkEn <= 1'b0;
        fetch.address <= 16'h0120;
        fetch.instruction <= immInstr(2'd3, 10'h011);
        @(posedge clk);
        resolve.endPulse <= 1'b1;
        resolve.mispredicted <= 1'b1;
        @(negedge clk);
        if (prediction.speculating) begin
            errors++;
            $display("Speculation started while clkEn was low");
        end
        @(posedge clk);
        resolve.endPulse <= 1'b0;
        fetch.instruction <= nopInstr;
        @(posedge clk);
        clkEn <= 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: branchExaminer.f
hw/branchIsaPkg.sv
hw/branchPredPkg.sv
hw/addressHasher.sv
hw/branchDecoder.sv
hw/predictionTable.sv
hw/speculationControl.sv
hw/branchExaminer.sv
dv/branchExaminerTb.sv

// File: run.sh
#!/bin/sh
# Builds the branch examiner testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module branchExaminerTb \
    -f branchExaminer.f -o branchExaminerSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/branchExaminerSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
